// File: verilog.f
hw/alu_pkg.sv
hw/exec_pkg.sv
hw/adder.sv
hw/alu.sv
hw/credit_fifo.sv
hw/exec_unit.sv
hw/alu_core_top.sv
dv/alu_core_assert.sv
dv/alu_core_tb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator and run the testbench; the log decides the result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module alu_core_tb -f verilog.f -o alu_core_sim

./obj_dir/alu_core_sim | tee sim.log

if grep -qx "TEST PASS" sim.log; then
   exit 0
else
   exit 1
fi

// File: dv/alu_core_tb.sv
`timescale 1ns/100ps

module alu_core_tb;

   localparam int          WAIT_LIMIT = 200;
   localparam logic [31:0] SEED       = 32'h5ccc_84a6;

   logic                 clk;
   logic                 rst_n;
   logic                 cmd_valid;
   alu_pkg::op_t         cmd_op;
   exec_pkg::reg_addr_t  cmd_dst;
   exec_pkg::reg_addr_t  cmd_src_a;
   exec_pkg::reg_addr_t  cmd_src_b;
   logic                 cmd_use_imm;
   alu_pkg::data_t       cmd_imm;
   logic                 cmd_credit;
   logic                 rsp_valid;
   exec_pkg::reg_addr_t  rsp_dst;
   alu_pkg::data_t       rsp_result;
   alu_pkg::flags_t      rsp_flags;
   logic                 rsp_credit;

   alu_pkg::data_t   model_regs [exec_pkg::REG_N];
   alu_pkg::flags_t  model_flags;
   exec_pkg::rsp_t   exp_q [$];
   logic [31:0]      stim_seed;
   logic [31:0]      cons_seed;
   int               cmds_sent;
   int               credits_back;
   int               rsp_seen;
   int               credits_given;
   int               errors;
   int               checks;
   int               test_errs;
   int               test_checks;
   int               tests_run;
   int               tests_bad;
   logic             hold_credits;
   logic             aborted;
   string            cur_test;

   alu_pkg::op_t arith_ops [6] = '{alu_pkg::OP_ADD, alu_pkg::OP_ADC, alu_pkg::OP_SUB,
                                   alu_pkg::OP_SBB, alu_pkg::OP_INC, alu_pkg::OP_DEC};
   alu_pkg::op_t logic_ops [8] = '{alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR,
                                   alu_pkg::OP_SHL, alu_pkg::OP_SHR, alu_pkg::OP_SHA,
                                   alu_pkg::OP_ROL, alu_pkg::OP_ROR};

   alu_core_top alu_core_top_inst (
      .clk (clk), .rst_n (rst_n), .cmd_valid (cmd_valid), .cmd_op (cmd_op),
      .cmd_dst (cmd_dst), .cmd_src_a (cmd_src_a), .cmd_src_b (cmd_src_b),
      .cmd_use_imm (cmd_use_imm), .cmd_imm (cmd_imm), .cmd_credit (cmd_credit),
      .rsp_valid (rsp_valid), .rsp_dst (rsp_dst), .rsp_result (rsp_result),
      .rsp_flags (rsp_flags), .rsp_credit (rsp_credit)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ==========================================================
   // Random numbers and reference model
   // ==========================================================
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int unsigned rand_u(input int unsigned n);
      stim_seed = lcg_next(stim_seed);
      return {16'd0, stim_seed[31:16]} % n;
   endfunction

   function automatic int cmd_avail();
      return exec_pkg::CMD_DEPTH - cmds_sent + credits_back;
   endfunction

   function automatic void alu_model(input exec_pkg::cmd_t c);
      alu_pkg::data_t   a;
      alu_pkg::data_t   b;
      alu_pkg::data_t   b_add;
      alu_pkg::data_t   res;
      logic             ci;
      logic             cin;
      logic             carry;
      logic [8:0]       sum;
      logic [15:0]      prod;
      alu_pkg::flags_t  f;
      exec_pkg::rsp_t   r;
      a  = (c.src_a == 3'd0) ? 8'h00 : model_regs[c.src_a];
      b  = c.use_imm ? c.imm : ((c.src_b == 3'd0) ? 8'h00 : model_regs[c.src_b]);
      ci = model_flags.c;
      b_add = b;
      if (c.op == alu_pkg::OP_SUB || c.op == alu_pkg::OP_SBB || c.op == alu_pkg::OP_CMP)
         b_add = ~b;
      if (c.op == alu_pkg::OP_INC) b_add = 8'h00;
      if (c.op == alu_pkg::OP_DEC) b_add = 8'hff;
      cin = (c.op == alu_pkg::OP_ADD || c.op == alu_pkg::OP_DEC) ? 1'b0 :
            (c.op == alu_pkg::OP_SUB || c.op == alu_pkg::OP_CMP ||
             c.op == alu_pkg::OP_INC) ? 1'b1 : ci;
      sum   = {1'b0, a} + {1'b0, b_add} + {8'd0, cin};
      prod  = {8'd0, a} * {8'd0, b};
      res   = a;  // Div and unused codes pass a and keep carry.
      carry = ci;
      case (c.op)
         alu_pkg::OP_ADD, alu_pkg::OP_ADC, alu_pkg::OP_SUB, alu_pkg::OP_SBB,
         alu_pkg::OP_INC, alu_pkg::OP_DEC, alu_pkg::OP_CMP: begin
            res   = sum[7:0];
            carry = sum[8];
         end
         alu_pkg::OP_AND: res = a & b;
         alu_pkg::OP_OR:  res = a | b;
         alu_pkg::OP_XOR: res = a ^ b;
         alu_pkg::OP_SHL: begin
            res   = a << 1;
            carry = a[7];
         end
         alu_pkg::OP_SHR: begin
            res   = a >> 1;
            carry = a[0];
         end
         alu_pkg::OP_SHA: begin
            res   = {a[7], a[7:1]};
            carry = a[0];
         end
         alu_pkg::OP_ROL: begin
            res   = {a[6:0], ci};
            carry = a[7];
         end
         alu_pkg::OP_ROR: begin
            res   = {ci, a[7:1]};
            carry = a[0];
         end
         alu_pkg::OP_MUL: res = prod[7:0];
         alu_pkg::OP_MUH: res = prod[15:8];
         alu_pkg::OP_STC: carry = 1'b1;
         alu_pkg::OP_CLC: carry = 1'b0;
         default: ;
      endcase
      f.c = carry;
      f.v = (a[7] == b_add[7]) && (sum[7] != a[7]);  // Adder overflow for every code.
      f.z = (res == 8'h00);
      f.s = res[7];
      if (c.op != alu_pkg::OP_CMP && c.dst != 3'd0) model_regs[c.dst] = res;
      model_flags = f;
      r.dst    = c.dst;
      r.result = res;
      r.flags  = f;
      exp_q.push_back(r);
   endfunction

   // ==========================================================
   // Checks
   // ==========================================================
   task automatic check_result(input alu_pkg::data_t want, input alu_pkg::data_t got);
      checks++;
      if (got !== want) begin
         errors++;
         $display("[ERROR] %s: result expected %h, got %h", cur_test, want, got);
      end
   endtask

   task automatic check_flags(input alu_pkg::flags_t want, input alu_pkg::flags_t got);
      checks++;
      if (got !== want) begin
         errors++;
         $display("[ERROR] %s: flags cvzs expected %b, got %b", cur_test, want, got);
      end
   endtask

   task automatic check_dst(input exec_pkg::reg_addr_t want, input exec_pkg::reg_addr_t got);
      checks++;
      if (got !== want) begin
         errors++;
         $display("[ERROR] %s: dst expected %0d, got %0d", cur_test, want, got);
      end
   endtask

   task automatic check_low(input string what, input logic got);
      checks++;
      if (got !== 1'b0) begin
         errors++;
         $display("[ERROR] %s: %s expected 0, got %b", cur_test, what, got);
      end
   endtask

   always @(posedge clk) begin : compare_rsp
      exec_pkg::rsp_t want;
      if (rst_n && rsp_valid) begin
         rsp_seen <= rsp_seen + 1;
         if (rsp_seen + 1 - credits_given > exec_pkg::RSP_CREDITS) begin
            errors++;
            $display("[ERROR] %s: response sent without downstream credit", cur_test);
         end
         if (exp_q.size() == 0) begin
            errors++;
            $display("[ERROR] %s: response arrived with no command outstanding", cur_test);
         end else begin
            want = exp_q.pop_front();
            check_dst(want.dst, rsp_dst);
            check_result(want.result, rsp_result);
            check_flags(want.flags, rsp_flags);
         end
      end
   end

   always @(posedge clk) begin
      if (rst_n && cmd_credit) begin
         credits_back <= credits_back + 1;
         if (credits_back >= cmds_sent) begin
            errors++;
            $display("[ERROR] %s: cmd_credit returned with no command outstanding", cur_test);
         end
      end
   end

   // Downstream consumer hands back one credit per response after a random delay.
   always @(posedge clk) begin
      cons_seed = lcg_next(cons_seed);
      if (rst_n && !hold_credits && rsp_seen != credits_given && cons_seed[31:30] != 2'b00) begin
         rsp_credit    <= 1'b1;
         credits_given <= credits_given + 1;
      end else begin
         rsp_credit <= 1'b0;
      end
   end

   // ==========================================================
   // Stimulus
   // ==========================================================
   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         cmd_valid <= 1'b0;
      end
   endtask

   task automatic send_cmd(input alu_pkg::op_t op, input exec_pkg::reg_addr_t dst,
                           input exec_pkg::reg_addr_t src_a, input exec_pkg::reg_addr_t src_b,
                           input logic use_imm, input alu_pkg::data_t imm);
      exec_pkg::cmd_t c;
      int             waited;
      c.op = op;
      c.dst = dst;
      c.src_a = src_a;
      c.src_b = src_b;
      c.use_imm = use_imm;
      c.imm = imm;
      waited = 0;
      if (!aborted) begin
         @(posedge clk);
         while (cmd_avail() <= 0 && waited < WAIT_LIMIT) begin
            cmd_valid <= 1'b0;
            waited++;
            @(posedge clk);
         end
         if (cmd_avail() <= 0) begin
            $display("%s: no command credit came back in %0d cycles", cur_test, WAIT_LIMIT);
            aborted = 1'b1;
            cmd_valid <= 1'b0;
         end else begin
            cmd_valid   <= 1'b1;
            cmd_op      <= op;
            cmd_dst     <= dst;
            cmd_src_a   <= src_a;
            cmd_src_b   <= src_b;
            cmd_use_imm <= use_imm;
            cmd_imm     <= imm;
            cmds_sent   <= cmds_sent + 1;
            alu_model(c);
         end
      end
   endtask

   task automatic send_random(input alu_pkg::op_t op);
      exec_pkg::reg_addr_t dst;
      exec_pkg::reg_addr_t src_a;
      exec_pkg::reg_addr_t src_b;
      logic                use_imm;
      alu_pkg::data_t      imm;
      dst     = exec_pkg::reg_addr_t'(rand_u(7) + 1);
      src_a   = exec_pkg::reg_addr_t'(rand_u(8));
      src_b   = exec_pkg::reg_addr_t'(rand_u(8));
      use_imm = (rand_u(4) == 0);
      imm     = alu_pkg::data_t'(rand_u(256));
      send_cmd(op, dst, src_a, src_b, use_imm, imm);
      if (rand_u(4) == 0) idle(rand_u(3) + 1);
   endtask

   task automatic load_regs();
      for (int r = 1; r < exec_pkg::REG_N; r++) begin
         send_cmd(alu_pkg::OP_OR, exec_pkg::reg_addr_t'(r), 3'd0, 3'd0, 1'b1,
                  alu_pkg::data_t'(rand_u(256)));
      end
   endtask

   // An OR into r0 returns a register's value without changing any register.
   task automatic read_regs();
      for (int r = 0; r < exec_pkg::REG_N; r++) begin
         send_cmd(alu_pkg::OP_OR, 3'd0, exec_pkg::reg_addr_t'(r), 3'd0, 1'b1, 8'h00);
      end
   endtask

   task automatic begin_test(input string name);
      cur_test    = name;
      test_errs   = errors;
      test_checks = checks;
   endtask

   task automatic end_test();
      int waited;
      waited = 0;
      idle(1);
      while (!aborted && !(rsp_seen == cmds_sent && credits_given == rsp_seen)
             && waited < WAIT_LIMIT) begin
         idle(1);
         waited++;
      end
      if (waited >= WAIT_LIMIT) begin
         $display("%s: responses did not drain within %0d cycles", cur_test, WAIT_LIMIT);
         aborted = 1'b1;
      end
      idle(2);
      tests_run++;
      if (errors != test_errs) tests_bad++;
      $display("%-12s %0d checks, %0d errors", cur_test, checks - test_checks,
               errors - test_errs);
   endtask

   initial begin
      int base;
      stim_seed = SEED;
      cons_seed = lcg_next(SEED);
      rst_n = 1'b0;
      cmd_valid = 1'b0;
      cmd_op = '0;
      cmd_dst = '0;
      cmd_src_a = '0;
      cmd_src_b = '0;
      cmd_use_imm = 1'b0;
      cmd_imm = '0;
      rsp_credit = 1'b0;
      cmds_sent = 0;
      credits_back = 0;
      rsp_seen = 0;
      credits_given = 0;
      errors = 0;
      checks = 0;
      tests_run = 0;
      tests_bad = 0;
      hold_credits = 1'b0;
      aborted = 1'b0;
      for (int r = 0; r < exec_pkg::REG_N; r++) model_regs[r] = 8'h00;
      model_flags = '0;

      begin_test("reset");
      repeat (4) begin
         @(posedge clk);
         check_low("rsp_valid", rsp_valid);
         check_low("cmd_credit", cmd_credit);
      end
      rst_n <= 1'b1;
      repeat (4) begin
         @(posedge clk);
         check_low("rsp_valid", rsp_valid);
         check_low("cmd_credit", cmd_credit);
      end
      end_test();

      begin_test("arith");
      load_regs();
      send_cmd(alu_pkg::OP_STC, 3'd0, 3'd0, 3'd0, 1'b0, 8'h00);
      send_cmd(alu_pkg::OP_ADC, 3'd1, 3'd2, 3'd3, 1'b0, 8'h00);
      send_cmd(alu_pkg::OP_SBB, 3'd4, 3'd5, 3'd0, 1'b1, 8'hff);
      send_cmd(alu_pkg::OP_ADD, 3'd6, 3'd6, 3'd0, 1'b1, 8'h80);  // Chain a carry into adc.
      send_cmd(alu_pkg::OP_ADC, 3'd7, 3'd1, 3'd2, 1'b0, 8'h00);
      repeat (40) send_random(arith_ops[rand_u(6)]);
      end_test();

      begin_test("logic");
      load_regs();
      send_cmd(alu_pkg::OP_STC, 3'd0, 3'd0, 3'd0, 1'b0, 8'h00);
      send_cmd(alu_pkg::OP_ROL, 3'd1, 3'd1, 3'd0, 1'b0, 8'h00);
      send_cmd(alu_pkg::OP_ROR, 3'd2, 3'd2, 3'd0, 1'b0, 8'h00);
      send_cmd(alu_pkg::OP_CLC, 3'd0, 3'd0, 3'd0, 1'b0, 8'h00);
      send_cmd(alu_pkg::OP_ROR, 3'd3, 3'd3, 3'd0, 1'b0, 8'h00);
      repeat (40) send_random(logic_ops[rand_u(8)]);
      end_test();

      begin_test("mul_special");
      load_regs();
      repeat (8) send_random(alu_pkg::OP_MUL);
      repeat (8) send_random(alu_pkg::OP_MUH);
      repeat (6) send_random(alu_pkg::OP_CMP);
      read_regs();
      send_cmd(alu_pkg::OP_STC, 3'd0, 3'd0, 3'd0, 1'b0, 8'h00);
      repeat (4) send_random(alu_pkg::OP_DIV);
      send_cmd(alu_pkg::OP_CLC, 3'd0, 3'd0, 3'd0, 1'b0, 8'h00);
      repeat (12) send_random(alu_pkg::op_t'(20 + rand_u(12)));
      read_regs();
      end_test();

      begin_test("registers");
      send_cmd(alu_pkg::OP_OR, 3'd0, 3'd0, 3'd0, 1'b1, 8'h5a);
      send_cmd(alu_pkg::OP_ADD, 3'd1, 3'd0, 3'd0, 1'b0, 8'h00);
      send_cmd(alu_pkg::OP_OR, 3'd1, 3'd0, 3'd0, 1'b1, 8'h17);  // Back-to-back chain follows.
      send_cmd(alu_pkg::OP_ADD, 3'd2, 3'd1, 3'd1, 1'b0, 8'h00);
      send_cmd(alu_pkg::OP_ADD, 3'd3, 3'd2, 3'd1, 1'b0, 8'h00);
      send_cmd(alu_pkg::OP_XOR, 3'd4, 3'd3, 3'd2, 1'b0, 8'h00);
      send_cmd(alu_pkg::OP_SUB, 3'd1, 3'd4, 3'd3, 1'b0, 8'h00);
      send_cmd(alu_pkg::OP_MUL, 3'd5, 3'd1, 3'd4, 1'b0, 8'h00);
      read_regs();
      end_test();

      begin_test("backpressure");
      hold_credits <= 1'b1;
      base = rsp_seen;
      repeat (exec_pkg::CMD_DEPTH + exec_pkg::RSP_DEPTH + exec_pkg::RSP_CREDITS) begin
         send_random(rand_u(2) == 0 ? arith_ops[rand_u(6)] : logic_ops[rand_u(8)]);
      end
      idle(20);
      checks++;
      if (!aborted && cmd_avail() != 0) begin
         errors++;
         $display("[ERROR] %s: sender credits expected 0, got %0d", cur_test, cmd_avail());
      end
      checks++;
      if (rsp_seen - base != exec_pkg::RSP_CREDITS) begin
         errors++;
         $display("[ERROR] %s: responses expected %0d, got %0d", cur_test,
                  exec_pkg::RSP_CREDITS, rsp_seen - base);
      end
      hold_credits <= 1'b0;
      end_test();

      $display("tests %0d, with errors %0d, checks %0d, errors %0d", tests_run, tests_bad,
               checks, errors);
      if (aborted || errors != 0
          || alu_core_top_inst.exec_unit_inst.alu_core_assert_inst.fail_cnt != 0) begin
         $display("TEST FAIL");
      end else begin
         $display("TEST PASS");
      end
      $finish;
   end

endmodule

// File: dv/alu_core_assert.sv
`timescale 1ns/100ps

module alu_core_assert (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             cmd_pop,
   input  logic             rsp_push,
   input  logic             rsp_pop,
   input  logic             rsp_valid,
   input  logic             rsp_credit,
   input  alu_pkg::flags_t  flags_q
);

   int rsp_occ;       // Response queue entries, counted from pushes and pops.
   int credit_avail;  // Downstream credits not yet spent on rsp_valid cycles.
   int fail_cnt = 0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_occ      <= 0;
         credit_avail <= exec_pkg::RSP_CREDITS;
      end else begin
         rsp_occ      <= rsp_occ + int'(rsp_push) - int'(rsp_pop);
         credit_avail <= credit_avail - int'(rsp_valid) + int'(rsp_credit);
      end
   end

   // ==========================================================
   // Execution unit checks
   // ==========================================================
   no_issue_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_pop |-> rsp_occ < exec_pkg::RSP_DEPTH)
      else begin
         fail_cnt++;
         $error("command issued while the response queue was full");
      end

   // Every rsp_valid cycle spends one credit granted by the consumer.
   valid_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid |-> credit_avail > 0)
      else begin
         fail_cnt++;
         $error("rsp_valid raised with no downstream credit");
      end

   flags_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(flags_q))
      else begin
         fail_cnt++;
         $error("flag register holds unknown bits");
      end

endmodule

bind exec_unit alu_core_assert alu_core_assert_inst (
   .clk (clk), .rst_n (rst_n), .cmd_pop (cmd_pop), .rsp_push (rsp_push),
   .rsp_pop (rsp_pop), .rsp_valid (rsp_valid), .rsp_credit (rsp_credit),
   .flags_q (flags_q)
);

// File: hw/alu_core_top.sv
`timescale 1ns/100ps

module alu_core_top (
   input  logic                 clk,
   input  logic                 rst_n,
   // Command port.
   input  logic                 cmd_valid,
   input  alu_pkg::op_t         cmd_op,
   input  exec_pkg::reg_addr_t  cmd_dst,
   input  exec_pkg::reg_addr_t  cmd_src_a,
   input  exec_pkg::reg_addr_t  cmd_src_b,
   input  logic                 cmd_use_imm,
   input  alu_pkg::data_t       cmd_imm,
   output logic                 cmd_credit,
   // Response port.
   output logic                 rsp_valid,
   output exec_pkg::reg_addr_t  rsp_dst,
   output alu_pkg::data_t       rsp_result,
   output alu_pkg::flags_t      rsp_flags,
   input  logic                 rsp_credit
);

   exec_pkg::cmd_t   cmd_in;
   exec_pkg::cmd_t   cmd_head;
   logic             cmd_empty;
   logic             cmd_pop;
   exec_pkg::rsp_t   rsp_data;
   exec_pkg::rsp_t   rsp_head;
   logic             rsp_push;
   logic             rsp_pop;
   logic             rsp_full;
   logic             rsp_empty;
   alu_pkg::op_t     alu_op;
   logic             alu_ci;
   alu_pkg::data_t   alu_a;
   alu_pkg::data_t   alu_b;
   alu_pkg::data_t   alu_res;
   logic             alu_co;
   logic             alu_vo;
   logic             alu_zo;
   logic             alu_so;

   assign cmd_in = '{op: cmd_op, dst: cmd_dst, src_a: cmd_src_a, src_b: cmd_src_b,
                     use_imm: cmd_use_imm, imm: cmd_imm};
   assign cmd_credit = cmd_pop;

   // Sender credits keep this queue from overflowing.
   credit_fifo #(.DEPTH(exec_pkg::CMD_DEPTH), .payload_t(exec_pkg::cmd_t)) cmd_fifo_inst (
      .clk (clk), .rst_n (rst_n),
      .push (cmd_valid), .push_data (cmd_in),
      .pop (cmd_pop), .pop_data (cmd_head),
      .full (), .empty (cmd_empty)
   );

   credit_fifo #(.DEPTH(exec_pkg::RSP_DEPTH), .payload_t(exec_pkg::rsp_t)) rsp_fifo_inst (
      .clk (clk), .rst_n (rst_n),
      .push (rsp_push), .push_data (rsp_data),
      .pop (rsp_pop), .pop_data (rsp_head),
      .full (rsp_full), .empty (rsp_empty)
   );

   exec_unit exec_unit_inst (
      .clk (clk), .rst_n (rst_n),
      .cmd_head (cmd_head), .cmd_empty (cmd_empty), .cmd_pop (cmd_pop),
      .alu_op (alu_op), .alu_ci (alu_ci), .alu_a (alu_a), .alu_b (alu_b),
      .alu_res (alu_res), .alu_co (alu_co), .alu_vo (alu_vo),
      .alu_zo (alu_zo), .alu_so (alu_so),
      .rsp_push (rsp_push), .rsp_data (rsp_data), .rsp_full (rsp_full),
      .rsp_pop (rsp_pop), .rsp_head (rsp_head), .rsp_empty (rsp_empty),
      .rsp_credit (rsp_credit), .rsp_valid (rsp_valid), .rsp_dst (rsp_dst),
      .rsp_result (rsp_result), .rsp_flags (rsp_flags)
   );

   alu #(.WIDTH(alu_pkg::DATA_W)) alu_inst (
      .op (alu_op), .ci (alu_ci), .ai (alu_a), .bi (alu_b),
      .res (alu_res), .co (alu_co), .vo (alu_vo), .zo (alu_zo), .so (alu_so)
   );

endmodule

// File: hw/exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
   input  logic                 clk,
   input  logic                 rst_n,
   // Command queue head.
   input  exec_pkg::cmd_t       cmd_head,
   input  logic                 cmd_empty,
   output logic                 cmd_pop,
   // ALU.
   output alu_pkg::op_t         alu_op,
   output logic                 alu_ci,
   output alu_pkg::data_t       alu_a,
   output alu_pkg::data_t       alu_b,
   input  alu_pkg::data_t       alu_res,
   input  logic                 alu_co,
   input  logic                 alu_vo,
   input  logic                 alu_zo,
   input  logic                 alu_so,
   // Response queue.
   output logic                 rsp_push,
   output exec_pkg::rsp_t       rsp_data,
   input  logic                 rsp_full,
   output logic                 rsp_pop,
   input  exec_pkg::rsp_t       rsp_head,
   input  logic                 rsp_empty,
   // Response port.
   input  logic                 rsp_credit,
   output logic                 rsp_valid,
   output exec_pkg::reg_addr_t  rsp_dst,
   output alu_pkg::data_t       rsp_result,
   output alu_pkg::flags_t      rsp_flags
);

   alu_pkg::data_t     regs [exec_pkg::REG_N];
   alu_pkg::flags_t    flags_q;
   alu_pkg::flags_t    flags_new;
   logic               issue;
   logic               wr_en;
   exec_pkg::credit_t  credit_cnt;

   // ==========================================================
   // Issue and operand read
   // ==========================================================
   assign issue   = !cmd_empty && !rsp_full;
   assign cmd_pop = issue;  // Also returned upstream as the command credit.

   assign alu_op = cmd_head.op;
   assign alu_ci = flags_q.c;
   assign alu_a  = (cmd_head.src_a == '0) ? '0 : regs[cmd_head.src_a];

   always_comb begin
      if (cmd_head.use_imm) begin
         alu_b = cmd_head.imm;
      end else if (cmd_head.src_b == '0) begin
         alu_b = '0;  // Register 0 reads as zero.
      end else begin
         alu_b = regs[cmd_head.src_b];
      end
   end

   assign flags_new = '{c: alu_co, v: alu_vo, z: alu_zo, s: alu_so};

   // Compare updates flags only.
   assign wr_en = issue && (cmd_head.op != alu_pkg::OP_CMP) && (cmd_head.dst != '0);

   // ==========================================================
   // Register file and flags
   // ==========================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < exec_pkg::REG_N; i++) begin
            regs[i] <= '0;
         end
         flags_q <= '0;
      end else begin
         if (wr_en) begin
            regs[cmd_head.dst] <= alu_res;
         end
         if (issue) begin
            flags_q <= flags_new;
         end
      end
   end

   assign rsp_push = issue;
   assign rsp_data = '{dst: cmd_head.dst, result: alu_res, flags: flags_new};

   // ==========================================================
   // Downstream credits and response output
   // ==========================================================
   assign rsp_pop = !rsp_empty && (credit_cnt != '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credit_cnt <= exec_pkg::credit_t'(exec_pkg::RSP_CREDITS);
         rsp_valid  <= 1'b0;
      end else begin
         credit_cnt <= credit_cnt - exec_pkg::credit_t'(rsp_pop)
                       + exec_pkg::credit_t'(rsp_credit);
         rsp_valid  <= rsp_pop;
      end
   end

   always_ff @(posedge clk) begin
      if (rsp_pop) begin
         rsp_dst    <= rsp_head.dst;
         rsp_result <= rsp_head.result;
         rsp_flags  <= rsp_head.flags;
      end
   end

endmodule

// File: hw/credit_fifo.sv
`timescale 1ns/100ps

module credit_fifo #(
   parameter int  DEPTH     = 4,
   parameter type payload_t = logic
) (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      push,
   input  payload_t  push_data,
   input  logic      pop,
   output payload_t  pop_data,
   output logic      full,
   output logic      empty
);

   payload_t                      mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]      wr_ptr;
   logic [$clog2(DEPTH)-1:0]      rd_ptr;
   logic [$clog2(DEPTH+1)-1:0]    count;
   logic                          do_push;
   logic                          do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither keeps occupancy.
         endcase
      end
   end

   assign pop_data = mem[rd_ptr];
   assign full     = (count == DEPTH);
   assign empty    = (count == 0);

endmodule

// File: hw/alu.sv
`timescale 1ns/100ps

module alu #(
   parameter int WIDTH = alu_pkg::DATA_W
) (
   input  alu_pkg::op_t    op,
   input  logic            ci,
   input  alu_pkg::data_t  ai,
   input  alu_pkg::data_t  bi,
   output alu_pkg::data_t  res,
   output logic            co,
   output logic            vo,
   output logic            zo,
   output logic            so
);

   logic                  cin;
   alu_pkg::data_t        op2;
   alu_pkg::data_t        ares;
   logic                  aco;
   logic [2*WIDTH-1:0]    mres;

   // ==========================================================
   // Operand conditioning
   // ==========================================================
   always_comb begin
      case (op)
         alu_pkg::OP_SUB, alu_pkg::OP_SBB, alu_pkg::OP_CMP: op2 = ~bi;
         alu_pkg::OP_INC: op2 = '0;
         alu_pkg::OP_DEC: op2 = '1;
         default:         op2 = bi;
      endcase
   end

   always_comb begin
      case (op)
         alu_pkg::OP_ADD, alu_pkg::OP_DEC: cin = 1'b0;
         alu_pkg::OP_SUB, alu_pkg::OP_CMP, alu_pkg::OP_INC: cin = 1'b1;
         default: cin = ci;  // Carry chain for adc and sbb.
      endcase
   end

   adder #(.WIDTH(WIDTH)) adder_inst (
      .ci  (cin),
      .ai  (ai),
      .bi  (op2),
      .res (ares),
      .co  (aco),
      .vo  (vo)  // Overflow is reported for every code.
   );

   assign mres = ai * bi;

   // ==========================================================
   // Result and carry selection
   // ==========================================================
   always_comb begin
      case (op)
         alu_pkg::OP_ADD, alu_pkg::OP_ADC, alu_pkg::OP_SUB, alu_pkg::OP_SBB,
         alu_pkg::OP_CMP, alu_pkg::OP_INC, alu_pkg::OP_DEC: res = ares;
         alu_pkg::OP_AND: res = ai & bi;
         alu_pkg::OP_OR:  res = ai | bi;
         alu_pkg::OP_XOR: res = ai ^ bi;
         alu_pkg::OP_SHL: res = {ai[WIDTH-2:0], 1'b0};
         alu_pkg::OP_SHR: res = {1'b0, ai[WIDTH-1:1]};
         alu_pkg::OP_SHA: res = {ai[WIDTH-1], ai[WIDTH-1:1]};
         alu_pkg::OP_ROL: res = {ai[WIDTH-2:0], ci};  // Rotates through carry.
         alu_pkg::OP_ROR: res = {ci, ai[WIDTH-1:1]};
         alu_pkg::OP_MUL: res = mres[WIDTH-1:0];
         alu_pkg::OP_MUH: res = mres[2*WIDTH-1:WIDTH];
         default:         res = ai;  // Div and unused codes.
      endcase
   end

   always_comb begin
      case (op)
         alu_pkg::OP_ADD, alu_pkg::OP_ADC, alu_pkg::OP_SUB, alu_pkg::OP_SBB,
         alu_pkg::OP_CMP, alu_pkg::OP_INC, alu_pkg::OP_DEC: co = aco;
         alu_pkg::OP_SHL, alu_pkg::OP_ROL: co = ai[WIDTH-1];
         alu_pkg::OP_SHR, alu_pkg::OP_SHA, alu_pkg::OP_ROR: co = ai[0];
         alu_pkg::OP_STC: co = 1'b1;
         alu_pkg::OP_CLC: co = 1'b0;
         default:         co = ci;
      endcase
   end

   assign zo = ~|res;
   assign so = res[WIDTH-1];

endmodule

// File: hw/adder.sv
`timescale 1ns/100ps

module adder #(
   parameter int WIDTH = alu_pkg::DATA_W
) (
   input  logic            ci,
   input  alu_pkg::data_t  ai,
   input  alu_pkg::data_t  bi,
   output alu_pkg::data_t  res,
   output logic            co,
   output logic            vo
);

   logic [WIDTH:0] sum;

   always_comb begin
      sum = {1'b0, ai} + {1'b0, bi} + {{WIDTH{1'b0}}, ci};
   end

   assign res = sum[WIDTH-1:0];
   assign co  = sum[WIDTH];

   // Same input signs but a different result sign.
   assign vo = (ai[WIDTH-1] == bi[WIDTH-1]) && (res[WIDTH-1] != ai[WIDTH-1]);

endmodule

// File: hw/exec_pkg.sv
package exec_pkg;

   // ==========================================================
   // Register file
   // ==========================================================
   localparam int REG_N  = 8;
   localparam int REG_AW = $clog2(REG_N);

   typedef logic [REG_AW-1:0] reg_addr_t;

   typedef struct packed {
      alu_pkg::op_t   op;
      reg_addr_t      dst;
      reg_addr_t      src_a;
      reg_addr_t      src_b;
      logic           use_imm;  // Operand b comes from imm.
      alu_pkg::data_t imm;
   } cmd_t;

   typedef struct packed {
      reg_addr_t        dst;
      alu_pkg::data_t   result;
      alu_pkg::flags_t  flags;
   } rsp_t;

   // ==========================================================
   // Queues and credits
   // ==========================================================
   localparam int CMD_DEPTH    = 4;  // Also the sender's starting credits.
   localparam int RSP_DEPTH    = 4;
   localparam int RSP_CREDITS  = 2;
   localparam int RSP_CREDIT_W = $clog2(RSP_CREDITS + 1);

   typedef logic [RSP_CREDIT_W-1:0] credit_t;

endpackage

// File: hw/alu_pkg.sv
package alu_pkg;

   // ==========================================================
   // Data path
   // ==========================================================
   localparam int DATA_W = 8;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [4:0]        op_t;

   // ==========================================================
   // Operation codes
   // ==========================================================
   localparam op_t OP_ADD = 5'd0;
   localparam op_t OP_ADC = 5'd1;
   localparam op_t OP_SUB = 5'd2;
   localparam op_t OP_SBB = 5'd3;
   localparam op_t OP_INC = 5'd4;
   localparam op_t OP_DEC = 5'd5;
   localparam op_t OP_AND = 5'd6;
   localparam op_t OP_OR  = 5'd7;
   localparam op_t OP_XOR = 5'd8;
   localparam op_t OP_SHL = 5'd9;
   localparam op_t OP_SHR = 5'd10;
   localparam op_t OP_ROL = 5'd11;
   localparam op_t OP_ROR = 5'd12;
   localparam op_t OP_MUL = 5'd13;
   localparam op_t OP_DIV = 5'd14;  // Passes operand a through.
   localparam op_t OP_CMP = 5'd15;
   localparam op_t OP_SHA = 5'd16;
   localparam op_t OP_STC = 5'd17;
   localparam op_t OP_CLC = 5'd18;
   localparam op_t OP_MUH = 5'd19;

   typedef struct packed {
      logic c;  // Carry.
      logic v;  // Signed overflow from the adder.
      logic z;
      logic s;
   } flags_t;

endpackage
